// ==== build.f ====
+incdir+hw
+incdir+sim
hw/endec_pkg.sv
hw/conv_encoder.sv
hw/sym_fifo.sv
hw/dec_control.sv
hw/acs_unit.sv
hw/survivor_mem.sv
hw/traceback.sv
hw/endec.sv
sim/tb_endec.sv

// ==== Bender.yml ====
package:
  name: endec

sources:
  - include_dirs:
      - hw
    files:
      - hw/endec_pkg.sv
      - hw/conv_encoder.sv
      - hw/sym_fifo.sv
      - hw/dec_control.sv
      - hw/acs_unit.sv
      - hw/survivor_mem.sv
      - hw/traceback.sv
      - hw/endec.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/tb_endec.sv

// ==== sim/tb_endec_model.svh ====
`ifndef TB_ENDEC_MODEL_SVH
`define TB_ENDEC_MODEL_SVH

// parity of the window bits selected by one generator.
function automatic logic tap_parity(
    input logic [`ENDEC_K-1:0] window,
    input logic [`ENDEC_K-1:0] taps
);
    logic p;
    p = 1'b0;
    for (int k = 0; k < `ENDEC_K; k++) begin
        if (taps[k]) begin
            p = p ^ window[k];
        end
    end
    return p;
endfunction

// code words of one frame from a cleared register, word i at [3*i +: 3].
function automatic logic [3*`ENDEC_FRAME-1:0] encode_frame(
    input code_rate_e              rate,
    input gen_poly_t               g,
    input logic [`ENDEC_FRAME-1:0] data
);
    logic [`ENDEC_K-1:0]       window;
    logic [3*`ENDEC_FRAME-1:0] words;
    sym_word_u                 w;
    window = '0;
    words  = '0;
    for (int i = 0; i < `ENDEC_FRAME; i++) begin
        window  = {data[i], window[`ENDEC_K-1:1]};  // new bit enters on top.
        w       = '0;
        w.r3.c0 = tap_parity(window, g.g0);
        w.r3.c1 = tap_parity(window, g.g1);
        if (rate == RATE_1_3) begin
            w.r3.c2 = tap_parity(window, g.g2);
        end
        words[3*i +: 3] = w;
    end
    return words;
endfunction

function automatic logic [`ENDEC_FRAME-1:0] random_frame(input logic zero_tail);
    logic [`ENDEC_FRAME-1:0] data;
    data = `ENDEC_FRAME'($urandom());
    if (zero_tail) begin
        data[`ENDEC_FRAME-1 -: 4] = '0;  // last four bits in time.
    end
    return data;
endfunction

// one active code bit flipped somewhere in the first 8 symbols.
function automatic logic [3*`ENDEC_FRAME-1:0] flip_code_bit(
    input logic [3*`ENDEC_FRAME-1:0] words,
    input code_rate_e                rate
);
    int unsigned sym_idx;
    int unsigned bit_idx;
    sym_idx = $urandom_range(7, 0);
    bit_idx = (rate == RATE_1_3) ? $urandom_range(2, 0) : $urandom_range(1, 0);
    words[3*sym_idx + bit_idx] = ~words[3*sym_idx + bit_idx];
    return words;
endfunction

`endif

// ==== sim/tb_endec.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module tb_endec;

    import endec_pkg::*;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 10;
    localparam int RESET_CYCLES     = 10;
    localparam int SEED             = 71029;
    localparam int FRAME            = `ENDEC_FRAME;
    localparam int DEPTH            = `ENDEC_FIFO_DEPTH;
    localparam int ENC_FRAMES       = 4;
    localparam int CLEAN_FRAMES     = 8;
    localparam int NOISY_FRAMES     = 4;
    localparam int DEC_FRAMES       = CLEAN_FRAMES + NOISY_FRAMES;
    localparam int GROUPS           = 2;
    localparam int CYCLES_PER_FRAME = 60;
    localparam int TOTAL_FRAMES     = GROUPS * (ENC_FRAMES + DEC_FRAMES);
    localparam longint WATCHDOG_NS  =
        longint'(TOTAL_FRAMES * CYCLES_PER_FRAME + GROUPS * RESET_CYCLES) * CLK_PERIOD;

    localparam gen_poly_t POLY_R2 = '{g2: 3'o0, g1: 3'o7, g0: 3'o5};
    localparam gen_poly_t POLY_R3 = '{g2: 3'o7, g1: 3'o7, g0: 3'o5};

    logic             sys_clk;
    logic             rst_n;
    code_rate_e       code_rate;
    gen_poly_t        gen_poly;
    logic             enc_valid;
    logic             enc_bit;
    sym_word_u        enc_word;
    logic             enc_out_valid;
    logic             enc_done;
    logic             sym_valid;
    sym_word_u        sym;
    logic             sym_credit;
    logic [FRAME-1:0] dec_data;
    logic             dec_done;

    logic             exp_enc_valid;
    logic             exp_enc_done;
    sym_word_u        exp_enc_word;
    logic [FRAME-1:0] enc_frames [ENC_FRAMES];
    logic [FRAME-1:0] exp_frames [DEC_FRAMES];
    logic [FRAME-1:0] exp_dec_data;
    sym_word_u        sym_q [$];
    int               sent;
    int               returned;
    int               credits;
    int               dec_count;
    int               frames_expected;

    `include "tb_endec_model.svh"

    endec dut_i (
        .i_sys_clk    (sys_clk),
        .i_rst_n      (rst_n),
        .i_code_rate  (code_rate),
        .i_gen_poly   (gen_poly),
        .i_enc_valid  (enc_valid),
        .i_enc_bit    (enc_bit),
        .o_enc_word   (enc_word),
        .o_enc_valid  (enc_out_valid),
        .o_enc_done   (enc_done),
        .i_sym_valid  (sym_valid),
        .i_sym        (sym),
        .o_sym_credit (sym_credit),
        .o_dec_data   (dec_data),
        .o_dec_done   (dec_done)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                 actual);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("error at time %0t: %s", $time, what);
        abort_run();
    endtask

    assign credits = DEPTH - sent + returned;  // sender's view.
    assign exp_dec_data = (dec_count < DEC_FRAMES) ? exp_frames[dec_count] : '0;

    // credit pulses and decoded frames, counted per clock.
    always @(posedge sys_clk) begin
        if (!rst_n) begin
            returned  <= 0;
            dec_count <= 0;
        end else begin
            if (sym_credit) begin
                returned <= returned + 1;
            end
            if (dec_done) begin
                dec_count <= dec_count + 1;
            end
        end
    end

    assert property (@(posedge sys_clk) disable iff (!rst_n) enc_out_valid == exp_enc_valid)
        else report_mismatch("o_enc_valid", 32'($sampled(exp_enc_valid)),
                             32'($sampled(enc_out_valid)));

    assert property (@(posedge sys_clk) disable iff (!rst_n)
                     exp_enc_valid |-> enc_word == exp_enc_word)
        else report_mismatch("o_enc_word", 32'($sampled(exp_enc_word)),
                             32'($sampled(enc_word)));

    assert property (@(posedge sys_clk) disable iff (!rst_n) enc_done == exp_enc_done)
        else report_mismatch("o_enc_done", 32'($sampled(exp_enc_done)),
                             32'($sampled(enc_done)));

    assert property (@(posedge sys_clk) disable iff (!rst_n)
                     dec_done |-> dec_data == exp_dec_data)
        else report_mismatch("o_dec_data", 32'($sampled(exp_dec_data)),
                             32'($sampled(dec_data)));

    assert property (@(posedge sys_clk) disable iff (!rst_n)
                     dec_done |-> dec_count < frames_expected)
        else report_error("o_dec_done pulsed with no frame left to decode");

    // 16 pops, and so 16 credits, between two frames.
    assert property (@(posedge sys_clk) disable iff (!rst_n)
                     dec_done |-> returned == FRAME * (dec_count + 1))
        else report_error("credits returned do not match 16 symbols per decoded frame");

    assert property (@(posedge sys_clk) disable iff (!rst_n) credits >= 0 && credits <= DEPTH)
        else report_error($sformatf("credit counter out of range: %0d", $sampled(credits)));

    task automatic check_reset_values();
        assert (enc_out_valid === 1'b0) else report_mismatch("o_enc_valid", 0, 32'(enc_out_valid));
        assert (enc_done === 1'b0) else report_mismatch("o_enc_done", 0, 32'(enc_done));
        assert (sym_credit === 1'b0) else report_mismatch("o_sym_credit", 0, 32'(sym_credit));
        assert (dec_done === 1'b0) else report_mismatch("o_dec_done", 0, 32'(dec_done));
        assert (dec_data === '0) else report_mismatch("o_dec_data", 0, 32'(dec_data));
    endtask

    task automatic apply_reset(input code_rate_e rate, input gen_poly_t poly);
        rst_n           = 1'b0;
        code_rate       = rate;  // config only moves while held in reset.
        gen_poly        = poly;
        enc_valid       = 1'b0;
        enc_bit         = 1'b0;
        sym_valid       = 1'b0;
        sym             = '0;
        exp_enc_valid   = 1'b0;
        exp_enc_done    = 1'b0;
        exp_enc_word    = '0;
        sent            = 0;
        frames_expected = 0;
        sym_q.delete();
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #DRIVE_DELAY;
        check_reset_values();
        rst_n = 1'b1;
        @(posedge sys_clk);
        #DRIVE_DELAY;
    endtask

    task automatic prepare_group(input code_rate_e rate, input gen_poly_t poly);
        logic [3*FRAME-1:0] words;
        for (int f = 0; f < ENC_FRAMES; f++) begin
            enc_frames[f] = random_frame(1'b0);
        end
        for (int f = 0; f < DEC_FRAMES; f++) begin
            exp_frames[f] = random_frame(f >= CLEAN_FRAMES);
            words = encode_frame(rate, poly, exp_frames[f]);
            if (f >= CLEAN_FRAMES) begin
                words = flip_code_bit(words, rate);
            end
            for (int i = 0; i < FRAME; i++) begin
                sym_q.push_back(sym_word_u'(words[3*i +: 3]));
            end
        end
        frames_expected = DEC_FRAMES;
    endtask

    task automatic run_encoder(input code_rate_e rate, input gen_poly_t poly);
        logic [3*FRAME-1:0] words;
        for (int f = 0; f < ENC_FRAMES; f++) begin
            words = encode_frame(rate, poly, enc_frames[f]);
            for (int i = 0; i < FRAME; i++) begin
                enc_valid = 1'b1;
                enc_bit   = enc_frames[f][i];
                @(posedge sys_clk);
                #DRIVE_DELAY;
                exp_enc_valid = 1'b1;  // word due one cycle after acceptance.
                exp_enc_word  = sym_word_u'(words[3*i +: 3]);
                exp_enc_done  = (i == FRAME - 1);
            end
        end
        enc_valid = 1'b0;
        enc_bit   = 1'b0;
        @(posedge sys_clk);
        #DRIVE_DELAY;
        exp_enc_valid = 1'b0;
        exp_enc_done  = 1'b0;
    endtask

    task automatic send_symbols();
        while (sym_q.size() > 0) begin
            if (credits > 0) begin
                sym_valid = 1'b1;
                sym       = sym_q.pop_front();
                sent      = sent + 1;
            end else begin
                sym_valid = 1'b0;  // stalled, waiting for a credit.
            end
            @(posedge sys_clk);
            #DRIVE_DELAY;
        end
        sym_valid = 1'b0;
        wait (dec_count == frames_expected);
        @(posedge sys_clk);
        #DRIVE_DELAY;
        assert (credits == DEPTH) else report_mismatch("credits", DEPTH, credits);
    endtask

    task automatic run_group(input code_rate_e rate, input gen_poly_t poly);
        apply_reset(rate, poly);
        prepare_group(rate, poly);
        fork
            run_encoder(rate, poly);
            send_symbols();
        join
    endtask

    initial begin
        void'($urandom(SEED));
        run_group(RATE_1_2, POLY_R2);
        run_group(RATE_1_3, POLY_R3);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog expired before all frames were encoded and decoded");
    end

endmodule

// ==== hw/endec.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module endec (
    input  logic                    i_sys_clk,
    input  logic                    i_rst_n,
    input  endec_pkg::code_rate_e   i_code_rate,
    input  endec_pkg::gen_poly_t    i_gen_poly,
    input  logic                    i_enc_valid,
    input  logic                    i_enc_bit,
    output endec_pkg::sym_word_u    o_enc_word,
    output logic                    o_enc_valid,
    output logic                    o_enc_done,
    input  logic                    i_sym_valid,
    input  endec_pkg::sym_word_u    i_sym,
    output logic                    o_sym_credit,
    output logic [`ENDEC_FRAME-1:0] o_dec_data,
    output logic                    o_dec_done
);

    import endec_pkg::*;

    dec_phase_e               phase;
    logic                     pop_valid;
    sym_word_u                pop_sym;
    logic [3:0]               step;
    logic                     frame_start;
    acs_result_t              acs_result;
    logic                     acs_valid;
    logic [`ENDEC_STATES-1:0] rd_decisions;

    conv_encoder u_encoder (
        .i_sys_clk   (i_sys_clk),
        .i_rst_n     (i_rst_n),
        .i_code_rate (i_code_rate),
        .i_gen_poly  (i_gen_poly),
        .i_valid     (i_enc_valid),
        .i_bit       (i_enc_bit),
        .o_word      (o_enc_word),
        .o_valid     (o_enc_valid),
        .o_done      (o_enc_done)
    );

    sym_fifo u_fifo (
        .i_sys_clk   (i_sys_clk),
        .i_rst_n     (i_rst_n),
        .i_phase     (phase),
        .i_push      (i_sym_valid),
        .i_sym       (i_sym),
        .o_pop_valid (pop_valid),
        .o_pop_sym   (pop_sym),
        .o_credit    (o_sym_credit)
    );

    dec_control u_ctrl (
        .i_sys_clk     (i_sys_clk),
        .i_rst_n       (i_rst_n),
        .i_pop_valid   (pop_valid),
        .o_phase       (phase),
        .o_step        (step),
        .o_frame_start (frame_start)
    );

    acs_unit u_acs (
        .i_sys_clk     (i_sys_clk),
        .i_rst_n       (i_rst_n),
        .i_code_rate   (i_code_rate),
        .i_gen_poly    (i_gen_poly),
        .i_frame_start (frame_start),
        .i_valid       (pop_valid),
        .i_sym         (pop_sym),
        .o_result      (acs_result),
        .o_valid       (acs_valid)
    );

    survivor_mem u_surv (
        .i_sys_clk      (i_sys_clk),
        .i_rst_n        (i_rst_n),
        .i_wr           (acs_valid),
        .i_wr_step      (step),
        .i_decisions    (acs_result.decisions),
        .i_rd_step      (step),
        .o_rd_decisions (rd_decisions)
    );

    traceback u_tb (
        .i_sys_clk    (i_sys_clk),
        .i_rst_n      (i_rst_n),
        .i_phase      (phase),
        .i_step       (step),
        .i_best_state (acs_result.best_state),
        .i_decisions  (rd_decisions),
        .o_dec_data   (o_dec_data),
        .o_dec_done   (o_dec_done)
    );

endmodule

// ==== hw/traceback.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module traceback (
    input  logic                     i_sys_clk,
    input  logic                     i_rst_n,
    input  endec_pkg::dec_phase_e    i_phase,
    input  logic [3:0]               i_step,
    input  logic [1:0]               i_best_state,
    input  logic [`ENDEC_STATES-1:0] i_decisions,
    output logic [`ENDEC_FRAME-1:0]  o_dec_data,
    output logic                     o_dec_done
);

    import endec_pkg::*;

    logic                    in_tb;
    logic                    in_tb_q;
    logic                    consume;
    logic [3:0]              step_q;   // step of the data now on i_decisions.
    logic [1:0]              state_q;
    logic [`ENDEC_FRAME-1:0] frame_q;

    assign in_tb   = (i_phase == PH_TB);
    assign consume = in_tb && in_tb_q;

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_tb_q    <= 1'b0;
            step_q     <= '0;
            state_q    <= '0;
            o_dec_data <= '0;
            o_dec_done <= 1'b0;
        end else begin
            in_tb_q    <= in_tb;
            step_q     <= i_step;
            o_dec_done <= (i_phase == PH_OUT);
            if (in_tb && !in_tb_q) begin
                state_q <= i_best_state;  // start from the winning end state.
            end else if (consume) begin
                state_q <= {state_q[0], i_decisions[state_q]};
            end
            if (i_phase == PH_OUT) begin
                o_dec_data <= frame_q;
            end
        end
    end

    // newest input bit sits in the state msb.
    always_ff @(posedge i_sys_clk) begin
        if (consume) begin
            frame_q[step_q] <= state_q[1];
        end
    end

endmodule

// ==== hw/survivor_mem.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module survivor_mem (
    input  logic                     i_sys_clk,
    input  logic                     i_rst_n,
    input  logic                     i_wr,
    input  logic [3:0]               i_wr_step,
    input  logic [`ENDEC_STATES-1:0] i_decisions,
    input  logic [3:0]               i_rd_step,
    output logic [`ENDEC_STATES-1:0] o_rd_decisions
);

    // one decision vector per trellis step.
    logic [`ENDEC_STATES-1:0] mem_q [`ENDEC_FRAME];

    always_ff @(posedge i_sys_clk) begin
        if (i_wr) begin
            mem_q[i_wr_step] <= i_decisions;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_decisions <= '0;
        end else begin
            o_rd_decisions <= mem_q[i_rd_step];  // data one cycle after address.
        end
    end

endmodule

// ==== hw/acs_unit.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module acs_unit (
    input  logic                   i_sys_clk,
    input  logic                   i_rst_n,
    input  endec_pkg::code_rate_e  i_code_rate,
    input  endec_pkg::gen_poly_t   i_gen_poly,
    input  logic                   i_frame_start,
    input  logic                   i_valid,
    input  endec_pkg::sym_word_u   i_sym,
    output endec_pkg::acs_result_t o_result,
    output logic                   o_valid
);

    import endec_pkg::*;

    localparam int NS   = `ENDEC_STATES;
    localparam int PM_W = `ENDEC_PM_W;
    localparam logic [PM_W-1:0] PM_INIT = PM_W'(8);

    logic [PM_W-1:0] pm_q    [NS];
    logic [PM_W-1:0] pm_base [NS];
    logic [PM_W-1:0] pm_new  [NS];
    logic [PM_W-1:0] pm_min;
    logic [NS-1:0]   dec;
    logic [1:0]      best_d;
    logic [1:0]      best_q;

    // hamming distance between expected and received code bits.
    function automatic logic [1:0] branch_dist(
        input logic [`ENDEC_K-1:0] win,
        input gen_poly_t           g,
        input code_rate_e          rate,
        input sym_word_u           sym
    );
        logic [2:0] diff;
        if (rate == RATE_1_3) begin
            diff = {^(win & g.g2) ^ sym.r3.c2,
                    ^(win & g.g1) ^ sym.r3.c1,
                    ^(win & g.g0) ^ sym.r3.c0};
        end else begin
            diff = {1'b0,
                    ^(win & g.g1) ^ sym.r2.c1,
                    ^(win & g.g0) ^ sym.r2.c0};
        end
        return 2'(diff[0]) + 2'(diff[1]) + 2'(diff[2]);
    endfunction

    always_comb begin
        for (int p = 0; p < NS; p++) begin
            if (i_frame_start) begin
                pm_base[p] = (p == 0) ? '0 : PM_INIT;
            end else begin
                pm_base[p] = pm_q[p];
            end
        end
    end

    // predecessors of s are {s[0], x}; branch window is {s, x}.
    for (genvar s = 0; s < NS; s++) begin : g_acs
        localparam logic [1:0] ST = 2'(s);
        logic [PM_W-1:0] cand0;
        logic [PM_W-1:0] cand1;
        assign cand0 = pm_base[{ST[0], 1'b0}]
                     + PM_W'(branch_dist({ST, 1'b0}, i_gen_poly, i_code_rate, i_sym));
        assign cand1 = pm_base[{ST[0], 1'b1}]
                     + PM_W'(branch_dist({ST, 1'b1}, i_gen_poly, i_code_rate, i_sym));
        assign dec[s]    = (cand1 < cand0);  // tie keeps lower predecessor.
        assign pm_new[s] = dec[s] ? cand1 : cand0;
    end

    always_comb begin
        pm_min = pm_new[0];
        best_d = '0;
        for (int s = 1; s < NS; s++) begin
            if (pm_new[s] < pm_min) begin
                pm_min = pm_new[s];
                best_d = 2'(s);
            end
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            best_q <= '0;
            for (int s = 0; s < NS; s++) begin
                pm_q[s] <= '0;
            end
        end else if (i_valid) begin
            best_q <= best_d;
            for (int s = 0; s < NS; s++) begin
                pm_q[s] <= pm_new[s] - pm_min;  // renormalize.
            end
        end
    end

    assign o_result.decisions  = dec;
    assign o_result.best_state = best_q;
    assign o_valid             = i_valid;

endmodule

// ==== hw/dec_control.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module dec_control (
    input  logic                  i_sys_clk,
    input  logic                  i_rst_n,
    input  logic                  i_pop_valid,
    output endec_pkg::dec_phase_e o_phase,
    output logic [3:0]            o_step,
    output logic                  o_frame_start
);

    import endec_pkg::*;

    localparam int STEP_W = $clog2(`ENDEC_FRAME);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`ENDEC_FRAME - 1);

    dec_phase_e        phase_q;
    logic [STEP_W-1:0] step_q;
    logic              drain_q;  // last read still in flight.

    assign o_phase       = phase_q;
    assign o_step        = step_q;
    assign o_frame_start = (phase_q == PH_ACS) && (step_q == '0);

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q <= PH_IDLE;
            step_q  <= '0;
            drain_q <= 1'b0;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    phase_q <= PH_ACS;
                    step_q  <= '0;
                end
                PH_ACS: begin
                    if (i_pop_valid) begin
                        if (step_q == LAST_STEP) begin
                            phase_q <= PH_TB;  // step stays on the last write.
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end
                end
                PH_TB: begin
                    if (drain_q) begin
                        drain_q <= 1'b0;
                        phase_q <= PH_OUT;
                    end else if (step_q == '0) begin
                        drain_q <= 1'b1;
                    end else begin
                        step_q <= step_q - 1'b1;
                    end
                end
                default: begin
                    phase_q <= PH_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/sym_fifo.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module sym_fifo (
    input  logic                  i_sys_clk,
    input  logic                  i_rst_n,
    input  endec_pkg::dec_phase_e i_phase,
    input  logic                  i_push,
    input  endec_pkg::sym_word_u  i_sym,
    output logic                  o_pop_valid,
    output endec_pkg::sym_word_u  o_pop_sym,
    output logic                  o_credit
);

    import endec_pkg::*;

    localparam int DEPTH = `ENDEC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    sym_word_u        buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             pop;

    // drains only while the decoder runs acs.
    assign pop         = (i_phase == PH_ACS) && (count_q != '0);
    assign o_pop_valid = pop;
    assign o_pop_sym   = buf_q[rd_ptr_q];

    always_ff @(posedge i_sys_clk) begin
        if (i_push) begin
            buf_q[wr_ptr_q] <= i_sym;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            o_credit <= 1'b0;
        end else begin
            o_credit <= pop;  // one credit per released slot.
            if (i_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== hw/conv_encoder.sv ====
`include "endec_consts.svh"
`timescale 1ns/1ns

module conv_encoder (
    input  logic                  i_sys_clk,
    input  logic                  i_rst_n,
    input  endec_pkg::code_rate_e i_code_rate,
    input  endec_pkg::gen_poly_t  i_gen_poly,
    input  logic                  i_valid,
    input  logic                  i_bit,
    output endec_pkg::sym_word_u  o_word,
    output logic                  o_valid,
    output logic                  o_done
);

    import endec_pkg::*;

    localparam int CNT_W = $clog2(`ENDEC_FRAME);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`ENDEC_FRAME - 1);

    logic [`ENDEC_K-2:0] mem_q;  // {newest, older}.
    logic [CNT_W-1:0]    cnt_q;
    logic [`ENDEC_K-1:0] window;
    logic                last_bit;
    sym_word_u           word_d;

    assign window   = {i_bit, mem_q};
    assign last_bit = (cnt_q == LAST_BIT);

    always_comb begin
        word_d = '0;
        if (i_code_rate == RATE_1_3) begin
            word_d.r3.c2 = ^(window & i_gen_poly.g2);
            word_d.r3.c1 = ^(window & i_gen_poly.g1);
            word_d.r3.c0 = ^(window & i_gen_poly.g0);
        end else begin
            word_d.r2.pad = 1'b0;
            word_d.r2.c1  = ^(window & i_gen_poly.g1);
            word_d.r2.c0  = ^(window & i_gen_poly.g0);
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_q   <= '0;
            cnt_q   <= '0;
            o_valid <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_done  <= i_valid && last_bit;
            if (i_valid) begin
                if (last_bit) begin
                    mem_q <= '0;  // flush between frames.
                    cnt_q <= '0;
                end else begin
                    mem_q <= window[`ENDEC_K-1:1];
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_valid) begin
            o_word <= word_d;
        end
    end

endmodule

// ==== hw/endec_pkg.sv ====
`include "endec_consts.svh"

package endec_pkg;

    typedef enum logic {
        RATE_1_2 = 1'b0,
        RATE_1_3 = 1'b1
    } code_rate_e;

    typedef struct packed {
        logic [`ENDEC_K-1:0] g2;  // unused at rate 1/2.
        logic [`ENDEC_K-1:0] g1;
        logic [`ENDEC_K-1:0] g0;
    } gen_poly_t;

    typedef struct packed {
        logic c2;
        logic c1;
        logic c0;
    } sym_r3_t;

    typedef struct packed {
        logic pad;  // zero on the encoder side.
        logic c1;
        logic c0;
    } sym_r2_t;

    // one code word, read through r2 or r3 by rate.
    typedef union packed {
        sym_r3_t r3;
        sym_r2_t r2;
    } sym_word_u;

    typedef struct packed {
        logic [`ENDEC_STATES-1:0] decisions;
        logic [1:0]               best_state;
    } acs_result_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ACS,
        PH_TB,
        PH_OUT
    } dec_phase_e;

endpackage

// ==== hw/endec_consts.svh ====
`ifndef ENDEC_CONSTS_SVH
`define ENDEC_CONSTS_SVH

// code shape
`define ENDEC_K          3   // constraint length.
`define ENDEC_STATES     4   // 2**(K-1) trellis states.
`define ENDEC_FRAME      16  // bits per frame.

// decoder sizing
`define ENDEC_PM_W       6   // path metric width.
`define ENDEC_FIFO_DEPTH 4   // symbol slots, also initial credits.

`endif
